// ==== src.f ====
+incdir+hdl
hdl/mdu_op_pkg.sv
hdl/mdu_hilo_pkg.sv
hdl/div_uu.sv
hdl/multi_cycle.sv
hdl/hilo_reg.sv
hdl/mdu_top.sv
verif/mdu_tb.sv

// ==== Makefile ====
# Verilator build for the HI/LO multiply-divide unit

VERILATOR ?= verilator
TOP       ?= mdu_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression passed" $(LOG); then \
		echo "Simulation result found in $(LOG)"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/mdu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mdu_tb;
    import mdu_op_pkg::*;
    import mdu_hilo_pkg::*;

    localparam int W           = `MDU_DATA_WIDTH;
    localparam int IDLE_LIMIT  = 100;
    localparam int FLUSH_AFTER = 10;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     flush;
    mdu_req_t req;
    logic     busy;
    hilo_t    hilo;

    logic [31:0] lfsr;
    hilo_t       model_state;
    int          checks = 0;
    int          errors = 0;
    int          outstanding = 0;

    // Expected results, in issue order
    string name_q[$];
    hilo_t exp_q[$];
    int    busy_q[$];

    always #4 clk = ~clk;

    mdu_top u_mdu_top (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .req   (req),
        .busy  (busy),
        .hilo  (hilo)
    );

    //////////////////////
    // Random numbers and reference model
    //////////////////////
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < 32; i++) begin
            val = {val[30:0], rand_bit()};
        end
        return val;
    endfunction

    function automatic hilo_t model_hilo(input mdu_op_e op, input logic uns,
            input logic [W-1:0] a, input logic [W-1:0] b, input hilo_t old);
        longint sa;
        longint sb;
        hilo_t  res;
        if (uns) begin
            sa = {32'b0, a};
            sb = {32'b0, b};
        end else begin
            sa = $signed(a);
            sb = $signed(b);
        end
        res = old;
        case (op)
            OP_MULT, OP_MUL: res = sa * sb;
            OP_MADD:         res = old + (sa * sb);
            OP_MSUB:         res = old - (sa * sb);
            OP_DIV: begin
                // Truncating divide, remainder keeps the dividend sign
                res.lo = 32'(sa / sb);
                res.hi = 32'(sa % sb);
            end
            OP_MTHI: res.hi = a;
            OP_MTLO: res.lo = a;
            default: res = old;
        endcase
        return res;
    endfunction

    //////////////////////
    // Reporting
    //////////////////////
    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        finish_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end else begin
            $display("ok     %s %h", name, actual);
        end
    endtask

    //////////////////////
    // Stimulus helpers
    //////////////////////
    function automatic mdu_req_t make_req(input mdu_op_e op, input logic uns,
            input logic [W-1:0] a, input logic [W-1:0] b);
        mdu_req_t r;
        r.valid       = 1'b1;
        r.op          = op;
        r.is_unsigned = uns;
        r.operand1    = a;
        r.operand2    = b;
        return r;
    endfunction

    // One-cycle request strobe
    task automatic drive_req(input mdu_req_t r);
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
    endtask

    task automatic queue_expect(input string name, input hilo_t expected, input int nbusy);
        name_q.push_back(name);
        exp_q.push_back(expected);
        busy_q.push_back(nbusy);
        outstanding++;
    endtask

    task automatic wait_idle();
        int guard;
        guard = 0;
        while (outstanding != 0) begin
            @(posedge clk);
            guard++;
            if (guard > IDLE_LIMIT) begin
                report_timeout("the result check to finish");
            end
        end
        @(posedge clk);
    endtask

    task automatic run_op(input mdu_op_e op, input logic uns, input logic [W-1:0] a,
            input logic [W-1:0] b, input string name);
        model_state = model_hilo(op, uns, a, b, model_state);
        queue_expect(name, model_state, (op == OP_DIV) ? `MDU_DIV_CYCLES : 0);
        drive_req(make_req(op, uns, a, b));
        wait_idle();
    endtask

    //////////////////////
    // Result checker
    //////////////////////
    always begin : compare
        string cname;
        hilo_t expected_hilo;
        int    exp_busy;
        int    cnt;
        int    guard;
        @(negedge clk);
        if (rst_n && req.valid) begin
            if (name_q.size() == 0) begin
                errors++;
                $display("A request was issued with no expected result queued");
            end else begin
                cname         = name_q.pop_front();
                expected_hilo = exp_q.pop_front();
                exp_busy      = busy_q.pop_front();
                if (exp_busy == 0) begin
                    @(negedge clk);
                end else begin
                    guard = 0;
                    while (!busy) begin
                        @(negedge clk);
                        guard++;
                        if (guard > 4) begin
                            report_timeout("busy to rise after a divide");
                        end
                    end
                    // Busy rises right after the accepting edge
                    check_value({cname, "_busy_rise"}, 64'd1, 64'(guard));
                    // Count the cycles busy is seen high
                    cnt = 0;
                    while (busy) begin
                        cnt++;
                        @(negedge clk);
                        if (cnt > 2 * `MDU_DIV_CYCLES) begin
                            report_timeout("busy to fall");
                        end
                    end
                    check_value({cname, "_busy"}, 64'(exp_busy), 64'(cnt));
                end
                check_value(cname, expected_hilo, hilo);
                outstanding--;
            end
        end
    end

    //////////////////////
    // Test sequence
    //////////////////////
    initial begin : stimulus
        logic         uns;
        mdu_op_e      op;
        logic [W-1:0] a;
        logic [W-1:0] b;
        hilo_t        before_div;
        lfsr        = 32'h605278d1;
        model_state = '0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        req         = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset_hilo", 64'h0, hilo);
        check_value("reset_busy", 64'h0, 64'(busy));
        run_op(OP_MTHI, 1'b0, rand_word(), rand_word(), "mthi");
        run_op(OP_MTLO, 1'b0, rand_word(), rand_word(), "mtlo");

        // Products, corners first
        run_op(OP_MULT, 1'b0, 32'h8000_0000, 32'h8000_0000, "mult_min_min");
        run_op(OP_MUL, 1'b1, 32'hFFFF_FFFF, 32'hFFFF_FFFF, "mulu_max_max");
        run_op(OP_MULT, 1'b0, 32'hFFFF_FFF9, 32'h8000_0003, "mult_neg_neg");
        run_op(OP_MUL, 1'b0, 32'h7FFF_FFFF, 32'h8000_0000, "mul_max_min");
        for (int i = 0; i < 12; i++) begin
            uns = rand_bit();
            op  = rand_bit() ? OP_MUL : OP_MULT;
            run_op(op, uns, rand_word(), rand_word(), $sformatf("mul_%0d", i));
        end

        // Accumulate chain onto a seeded HI/LO
        run_op(OP_MTHI, 1'b0, rand_word(), 32'h0, "seed_hi");
        run_op(OP_MTLO, 1'b0, rand_word(), 32'h0, "seed_lo");
        for (int i = 0; i < 12; i++) begin
            uns = rand_bit();
            op  = rand_bit() ? OP_MSUB : OP_MADD;
            run_op(op, uns, rand_word(), rand_word(), $sformatf("macc_%0d", i));
        end

        // Divides
        run_op(OP_DIV, 1'b0, 32'hFFFF_FFF9, 32'd2, "div_neg_dividend");
        run_op(OP_DIV, 1'b0, 32'd7, 32'hFFFF_FFFE, "div_neg_divisor");
        run_op(OP_DIV, 1'b0, 32'h8000_0000, 32'hFFFF_FFFF, "div_min_by_neg1");
        run_op(OP_DIV, 1'b1, 32'hFFFF_FFFF, 32'd3, "divu_max_by_3");
        for (int i = 0; i < 6; i++) begin
            a = rand_word();
            b = rand_word();
            if (rand_bit()) begin
                b = b >> 20;
            end
            if (b == '0) begin
                b = 32'd1;
            end
            run_op(OP_DIV, rand_bit(), a, b, $sformatf("div_%0d", i));
        end

        // MUL during a divide is dropped
        a = rand_word();
        before_div  = model_state;
        model_state = model_hilo(OP_DIV, 1'b0, a, 32'd13, model_state);
        queue_expect("div_with_drop", model_state, `MDU_DIV_CYCLES);
        drive_req(make_req(OP_DIV, 1'b0, a, 32'd13));
        repeat (5) @(posedge clk);
        drive_req(make_req(OP_MUL, 1'b0, rand_word(), rand_word()));
        @(negedge clk);
        check_value("drop_hold", before_div, hilo);
        wait_idle();

        // Flush in mid-divide, HI/LO keeps its value
        // Busy from the accepting edge up to the edge that samples flush
        queue_expect("div_flushed", model_state, FLUSH_AFTER + 1);
        drive_req(make_req(OP_DIV, 1'b0, rand_word(), 32'd7));
        repeat (FLUSH_AFTER) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        wait_idle();
        run_op(OP_DIV, 1'b0, rand_word(), 32'hFFFF_FF05, "div_after_flush");

        finish_run();
    end

endmodule

`default_nettype wire

// ==== hdl/mdu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  mdu_op_pkg::mdu_req_t req,
    output logic                 busy,
    output mdu_hilo_pkg::hilo_t  hilo
);
    import mdu_hilo_pkg::*;

    hilo_wr_t hilo_wr;

    // Datapath, current HI/LO fed back for accumulate
    multi_cycle u_multi_cycle (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .req     (req),
        .hilo    (hilo),
        .busy    (busy),
        .hilo_wr (hilo_wr)
    );

    hilo_reg u_hilo_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .hilo_wr (hilo_wr),
        .hilo    (hilo)
    );

endmodule

`default_nettype wire

// ==== hdl/hilo_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module hilo_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mdu_hilo_pkg::hilo_wr_t hilo_wr,
    output mdu_hilo_pkg::hilo_t    hilo
);

    // Each half updates on its own enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hilo <= '0;
        end else begin
            if (hilo_wr.we_hi) begin
                hilo.hi <= hilo_wr.data.hi;
            end
            if (hilo_wr.we_lo) begin
                hilo.lo <= hilo_wr.data.lo;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/multi_cycle.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module multi_cycle (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  mdu_op_pkg::mdu_req_t   req,
    input  mdu_hilo_pkg::hilo_t    hilo,
    output logic                   busy,
    output mdu_hilo_pkg::hilo_wr_t hilo_wr
);
    import mdu_op_pkg::*;
    import mdu_hilo_pkg::*;

    localparam int W      = `MDU_DATA_WIDTH;
    localparam int STAGES = `MDU_DIV_CYCLES;

    logic           accept;
    logic           sign_op1;
    logic           sign_op2;
    logic [W-1:0]   abs_op1;
    logic [W-1:0]   abs_op2;
    logic [2*W-1:0] prod_abs;
    logic [2*W-1:0] prod;

    // One-hot stage counter, one bit per busy cycle
    logic [STAGES-1:0] div_stage;
    logic              div_start;
    logic [W-1:0]      div_a;
    logic [W-1:0]      div_b;
    logic              div_neg_q;
    logic              div_neg_r;
    logic [W-1:0]      quo_abs;
    logic [W-1:0]      rem_abs;
    hilo_t             div_result;

    assign accept = req.valid && !busy;

    ////////////////////
    // Operand signs and multiply
    ////////////////////
    assign sign_op1 = !req.is_unsigned && req.operand1[W-1];
    assign sign_op2 = !req.is_unsigned && req.operand2[W-1];
    assign abs_op1  = sign_op1 ? -req.operand1 : req.operand1;
    assign abs_op2  = sign_op2 ? -req.operand2 : req.operand2;

    assign prod_abs = {{W{1'b0}}, abs_op1} * {{W{1'b0}}, abs_op2};
    assign prod     = (sign_op1 ^ sign_op2) ? -prod_abs : prod_abs;

    ////////////////////
    // Divide sequencing
    ////////////////////
    assign div_start = accept && (req.op == OP_DIV);
    assign busy      = |div_stage;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_stage <= '0;
        end else if (flush && busy) begin
            div_stage <= '0;
        end else if (busy) begin
            div_stage <= div_stage >> 1;
        end else if (div_start) begin
            div_stage <= {1'b1, {(STAGES-1){1'b0}}};
        end
    end

    // Operands held steady for the whole divide
    always_ff @(posedge clk) begin
        if (div_start) begin
            div_a     <= abs_op1;
            div_b     <= abs_op2;
            div_neg_q <= sign_op1 ^ sign_op2;
            div_neg_r <= sign_op1;
        end
    end

    div_uu #(
        .z_width(2 * W)
    ) u_div_uu (
        .clk (clk),
        .ena (busy),
        .z   ({{W{1'b0}}, div_a}),
        .d   (div_b),
        .q   (quo_abs),
        .s   (rem_abs)
    );

    // Remainder follows the dividend sign
    assign div_result.hi = div_neg_r ? -rem_abs : rem_abs;
    assign div_result.lo = div_neg_q ? -quo_abs : quo_abs;

    ////////////////////
    // HI/LO write selection
    ////////////////////
    always_comb begin
        hilo_wr = '0;
        if (div_stage[0] && !flush) begin
            hilo_wr.we_hi = 1'b1;
            hilo_wr.we_lo = 1'b1;
            hilo_wr.data  = div_result;
        end else if (accept) begin
            case (req.op)
                OP_MULT, OP_MUL: begin
                    hilo_wr.we_hi = 1'b1;
                    hilo_wr.we_lo = 1'b1;
                    hilo_wr.data  = prod;
                end
                OP_MADD: begin
                    hilo_wr.we_hi = 1'b1;
                    hilo_wr.we_lo = 1'b1;
                    hilo_wr.data  = hilo + prod;
                end
                OP_MSUB: begin
                    hilo_wr.we_hi = 1'b1;
                    hilo_wr.we_lo = 1'b1;
                    hilo_wr.data  = hilo - prod;
                end
                OP_MTHI: begin
                    hilo_wr.we_hi   = 1'b1;
                    hilo_wr.data.hi = req.operand1;
                end
                OP_MTLO: begin
                    hilo_wr.we_lo   = 1'b1;
                    hilo_wr.data.lo = req.operand1;
                end
                default: begin
                    hilo_wr = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/div_uu.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_uu #(
    parameter int z_width = 64
) (
    input  logic                 clk,
    input  logic                 ena,
    input  logic [z_width-1:0]   z,
    input  logic [z_width/2-1:0] d,
    output logic [z_width/2-1:0] q,
    output logic [z_width/2-1:0] s
);

    localparam int d_width = z_width / 2;

    // Per stage: partial remainder, quotient bits so far, divisor
    logic [z_width-1:0] pr [0:d_width];
    logic [d_width-1:0] qr [0:d_width];
    logic [d_width-1:0] dr [0:d_width];

    // Input register stage
    always_ff @(posedge clk) begin
        if (ena) begin
            pr[0] <= z;
            qr[0] <= '0;
            dr[0] <= d;
        end
    end

    ////////////////////
    // Restoring stages, one quotient bit each
    ////////////////////
    for (genvar k = 1; k <= d_width; k++) begin : g_stage
        logic [z_width:0]   shifted;
        logic [d_width:0]   top;
        logic [d_width:0]   diff;
        logic               ge;
        logic [d_width-1:0] next_hi;

        assign shifted = {pr[k-1], 1'b0};
        assign top     = shifted[z_width:d_width];
        assign diff    = top - {1'b0, dr[k-1]};
        assign ge      = (top >= {1'b0, dr[k-1]});
        // Partial remainder is always below the divisor, so d_width bits suffice
        assign next_hi = ge ? diff[d_width-1:0] : top[d_width-1:0];

        always_ff @(posedge clk) begin
            if (ena) begin
                pr[k] <= {next_hi, shifted[d_width-1:0]};
                qr[k] <= {qr[k-1][d_width-2:0], ge};
                dr[k] <= dr[k-1];
            end
        end
    end

    // Final stage holds the quotient and the remainder in the upper half
    assign q = qr[d_width];
    assign s = pr[d_width][z_width-1:d_width];

endmodule

`default_nettype wire

// ==== hdl/mdu_hilo_pkg.sv ====
`default_nettype none

`include "mdu_config.svh"

package mdu_hilo_pkg;

    // Architectural HI/LO pair
    typedef struct packed {
        logic [`MDU_DATA_WIDTH-1:0] hi;
        logic [`MDU_DATA_WIDTH-1:0] lo;
    } hilo_t;

    // Write port, one enable per half
    typedef struct packed {
        logic  we_hi;
        logic  we_lo;
        hilo_t data;
    } hilo_wr_t;

endpackage

`default_nettype wire

// ==== hdl/mdu_op_pkg.sv ====
`default_nettype none

`include "mdu_config.svh"

package mdu_op_pkg;

    // Operations understood by the multiply-divide unit
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_MULT = 3'd1,
        OP_MUL  = 3'd2,
        OP_MADD = 3'd3,
        OP_MSUB = 3'd4,
        OP_DIV  = 3'd5,
        OP_MTHI = 3'd6,
        OP_MTLO = 3'd7
    } mdu_op_e;

    // Single-cycle request strobe from the core
    typedef struct packed {
        logic                       valid;
        mdu_op_e                    op;
        logic                       is_unsigned;
        logic [`MDU_DATA_WIDTH-1:0] operand1;
        logic [`MDU_DATA_WIDTH-1:0] operand2;
    } mdu_req_t;

endpackage

`default_nettype wire

// ==== hdl/mdu_config.svh ====
`ifndef MDU_CONFIG_SVH
`define MDU_CONFIG_SVH

// Operand width of the core datapath
`define MDU_DATA_WIDTH 32

// Cycles busy stays high for a divide.
// Divider stages plus input and output registering
`define MDU_DIV_CYCLES 34

`endif
